// ==== bench/ccis_bridge_stimulus.txt ====
# cmd: 0 idle, 1 read, 2 write, 3 fence, 4 hold write rsp, 5 native c0 af, 6 expect c1 af, 7 drain
# cmd afu_type address mdata arg(cl_len, cycles or level) native_type
1 0 00001000 0a31 3 6
1 1 00002004 0b42 1 4
1 0 00003000 0c53 0 6
1 1 00004008 0d64 2 4
2 2 00005000 1001 0 1
2 3 00005040 1002 0 2
3 4 00000000 2001 0 5
2 2 00005080 1003 0 1
7 0 00000000 0000 0 0
5 0 00000000 0000 1 0
1 0 00006000 0e75 3 6
1 1 00007000 0f86 1 4
0 0 00000000 0000 20 0
5 0 00000000 0000 0 0
7 0 00000000 0000 0 0
4 0 00000000 0000 1 0
2 2 00008000 3001 0 1
2 3 00008040 3002 0 2
2 2 00008080 3003 0 1
2 3 000080c0 3004 0 2
2 2 00008100 3005 0 1
2 3 00008140 3006 0 2
2 2 00008180 3007 0 1
2 3 000081c0 3008 0 2
2 2 00008200 3009 0 1
2 3 00008240 300a 0 2
2 2 00008280 300b 0 1
2 3 000082c0 300c 0 2
6 0 00000000 0000 1 0
4 0 00000000 0000 0 0
7 0 00000000 0000 0 0
6 0 00000000 0000 0 0
1 0 00009000 0a17 3 6
3 4 00000000 2002 0 5
2 2 0000a000 1004 0 1
1 1 0000b004 0b28 1 4

// ==== bench/ccis_bridge_tb.sv ====
// Testbench for the bridge with a native cache port model that answers out of order
`timescale 1ns/10ps
`default_nettype none

module ccis_bridge_tb
    import ccis_bridge_pkg::*;
;

    logic clk;
    logic reset;
    c0_req_t afu_c0_tx;
    c1_req_t afu_c1_tx;
    logic afu_c0_tx_almost_full;
    logic afu_c1_tx_almost_full;
    c0_rsp_t afu_c0_rx;
    c1_rsp_t afu_c1_rx;
    native_req_t native_c0_tx;
    native_req_t native_c1_tx;
    native_rsp_t native_c0_rx;
    native_rsp_t native_c1_rx;
    logic native_c0_tx_almost_full;
    logic native_c1_tx_almost_full;

    // Expected traffic and native model state
    native_req_t rd_exp_q[$];
    native_req_t wr_exp_q[$];
    c0_rsp_t rd_rsp_exp[heap_idx_t];
    c1_rsp_t c1_rsp_exp[mdata_t];
    mdata_t rd_mdata_q[$];
    addr_t rd_addr_q[$];
    int rd_due_q[$];
    mdata_t wr_mdata_q[$];
    c0_rsp_t c0_next;
    bit c0_next_valid;
    bit hold_writes;
    int cycles;
    int cycle_limit;

    ccis_bridge ccis_bridge_inst
    (
        .clk(clk),
        .reset(reset),
        .afu_c0_tx(afu_c0_tx),
        .afu_c1_tx(afu_c1_tx),
        .afu_c0_tx_almost_full(afu_c0_tx_almost_full),
        .afu_c1_tx_almost_full(afu_c1_tx_almost_full),
        .afu_c0_rx(afu_c0_rx),
        .afu_c1_rx(afu_c1_rx),
        .native_c0_tx(native_c0_tx),
        .native_c1_tx(native_c1_tx),
        .native_c0_rx(native_c0_rx),
        .native_c1_rx(native_c1_rx),
        .native_c0_tx_almost_full(native_c0_tx_almost_full),
        .native_c1_tx_almost_full(native_c1_tx_almost_full)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Native read data is the inverted line address
    function automatic data_t line_data(addr_t a);
        return ~data_t'(a);
    endfunction

    function automatic data_t write_data(addr_t a, mdata_t m);
        return {a, 16'h0, m};
    endfunction

    // --------------------
    // Failure reporting and compare tasks

    task automatic stop_with_failure(string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_native_req(string name, native_req_t act, native_req_t exp);
        if (act !== exp)
        begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_with_failure("native request mismatch");
        end
    endtask

    task automatic check_c0_rsp(string name, c0_rsp_t act, c0_rsp_t exp);
        if (act !== exp)
        begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_with_failure("read response mismatch");
        end
    endtask

    task automatic check_c1_rsp(string name, c1_rsp_t act, c1_rsp_t exp);
        if (act !== exp)
        begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_with_failure("write response mismatch");
        end
    endtask

    task automatic check_flag(string name, logic act, logic exp);
        if (act !== exp)
        begin
            $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
            stop_with_failure("flag mismatch");
        end
    endtask

    // --------------------
    // Monitor, sampled at the falling edge where all outputs are settled

    always @(negedge clk)
    begin
        native_req_t exp_req;
        c0_rsp_t exp_rsp;
        heap_idx_t tag;

        cycles++;
        if (cycles > cycle_limit)
        begin
            stop_with_failure("timeout: the run took longer than the cycle limit");
        end
        if (!reset)
        begin
            if (c0_next_valid)
            begin
                check_c0_rsp("afu_c0_rx", afu_c0_rx, c0_next);
            end
            else if (afu_c0_rx.valid)
            begin
                stop_with_failure("read response on afu_c0_rx without a native response");
            end
            c0_next_valid = 1'b0;
            if (native_c0_rx.valid && native_c0_rx.resp_type == NRSP_RDLINE)
            begin
                tag = heap_idx_t'(native_c0_rx.mdata);
                c0_next = rd_rsp_exp[tag];
                c0_next_valid = 1'b1;
                rd_rsp_exp.delete(tag);
            end

            if (native_c0_tx.valid)
            begin
                if (native_c0_tx_almost_full)
                begin
                    stop_with_failure("native read issued while native almost-full was high");
                end
                if (rd_exp_q.size() == 0)
                begin
                    stop_with_failure("unexpected native read request");
                end
                exp_req = rd_exp_q.pop_front();
                exp_rsp = '0;
                exp_rsp.valid = 1'b1;
                exp_rsp.resp_type = RSP_RDLINE;
                exp_rsp.mdata = exp_req.mdata;
                exp_rsp.cl_num = cl_num_t'(exp_req.data);
                exp_rsp.data = line_data(exp_req.address);
                // Low mdata bits carry the tag that the bridge picks
                tag = heap_idx_t'(native_c0_tx.mdata);
                exp_req.mdata[$bits(heap_idx_t)-1:0] = tag;
                exp_req.data = '0;
                check_native_req("native_c0_tx", native_c0_tx, exp_req);
                if (rd_rsp_exp.exists(tag))
                begin
                    stop_with_failure("native read tag reused while still outstanding");
                end
                rd_rsp_exp[tag] = exp_rsp;
                rd_mdata_q.push_back(native_c0_tx.mdata);
                rd_addr_q.push_back(native_c0_tx.address);
                rd_due_q.push_back(int'($urandom_range(1, 10)));
            end

            if (native_c1_tx.valid)
            begin
                if (wr_exp_q.size() == 0)
                begin
                    stop_with_failure("unexpected native write request");
                end
                check_native_req("native_c1_tx", native_c1_tx, wr_exp_q.pop_front());
                if (native_c1_tx.req_type != NREQ_WRFENCE)
                begin
                    wr_mdata_q.push_back(native_c1_tx.mdata);
                end
            end

            if (afu_c1_rx.valid)
            begin
                if (!c1_rsp_exp.exists(afu_c1_rx.mdata))
                begin
                    stop_with_failure("write response with unknown or repeated mdata");
                end
                check_c1_rsp("afu_c1_rx", afu_c1_rx, c1_rsp_exp[afu_c1_rx.mdata]);
                c1_rsp_exp.delete(afu_c1_rx.mdata);
            end
        end
    end

    // --------------------
    // Native side model

    initial
    begin
        int start;
        int idx;
        int pick;
        bit c0_used;

        native_c0_rx = '0;
        native_c1_rx = '0;
        forever
        begin
            @(posedge clk);
            #1;
            native_c0_rx = '0;
            native_c1_rx = '0;
            c0_used = 1'b0;
            for (int i = 0; i < rd_due_q.size(); i++)
            begin
                if (rd_due_q[i] > 0)
                begin
                    rd_due_q[i]--;
                end
            end
            pick = -1;
            if (rd_due_q.size() > 0)
            begin
                start = int'($urandom_range(0, rd_due_q.size() - 1));
                for (int k = 0; k < rd_due_q.size(); k++)
                begin
                    idx = (start + k) % rd_due_q.size();
                    if (pick < 0 && rd_due_q[idx] == 0)
                    begin
                        pick = idx;
                    end
                end
            end
            if (pick >= 0)
            begin
                native_c0_rx = '{1'b1, NRSP_RDLINE, rd_mdata_q[pick],
                                 line_data(rd_addr_q[pick])};
                c0_used = 1'b1;
                rd_mdata_q.delete(pick);
                rd_addr_q.delete(pick);
                rd_due_q.delete(pick);
            end
            if (!hold_writes && wr_mdata_q.size() > 0)
            begin
                if ($urandom_range(0, 1) == 0 && !c0_used)
                begin
                    native_c0_rx = '{1'b1, NRSP_WRLINE, wr_mdata_q.pop_front(), '0};
                end
                else
                begin
                    native_c1_rx = '{1'b1, NRSP_WRLINE, wr_mdata_q.pop_front(), '0};
                end
            end
        end
    end

    // --------------------
    // Stimulus drivers

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue_read(int t, addr_t a, mdata_t m, int len, int nt);
        native_req_t exp_req;

        while (afu_c0_tx_almost_full)
        begin
            next_cycle();
        end
        afu_c0_tx = '{1'b1, req_e'(t), a, m, cl_num_t'(len)};
        // Data field of the expected item holds the line number
        for (int b = 0; b <= len; b++)
        begin
            exp_req = '{1'b1, native_req_e'(nt), a | addr_t'(b), m, data_t'(b)};
            rd_exp_q.push_back(exp_req);
        end
        next_cycle();
        afu_c0_tx = '0;
    endtask

    task automatic issue_write(int t, addr_t a, mdata_t m, int nt);
        native_req_t exp_req;
        c1_rsp_t exp_rsp;

        while (afu_c1_tx_almost_full)
        begin
            next_cycle();
        end
        afu_c1_tx = '{1'b1, req_e'(t), a, m, write_data(a, m)};
        exp_req = '{1'b1, native_req_e'(nt), a, m, write_data(a, m)};
        wr_exp_q.push_back(exp_req);
        exp_rsp.valid = 1'b1;
        exp_rsp.mdata = m;
        if (req_e'(t) == REQ_WRFENCE)
        begin
            exp_rsp.resp_type = RSP_WRFENCE;
        end
        else
        begin
            exp_rsp.resp_type = RSP_WRLINE;
        end
        c1_rsp_exp[m] = exp_rsp;
        next_cycle();
        afu_c1_tx = '0;
    endtask

    task automatic drain();
        while (rd_exp_q.size() || wr_exp_q.size() || rd_rsp_exp.size() ||
               c1_rsp_exp.size() || c0_next_valid)
        begin
            next_cycle();
        end
        next_cycle();
        // Nothing queued, so neither side may signal almost-full
        check_flag("afu_c0_tx_almost_full", afu_c0_tx_almost_full, 1'b0);
        check_flag("afu_c1_tx_almost_full", afu_c1_tx_almost_full, 1'b0);
    endtask

    initial
    begin
        int fd;
        int n;
        int cmd;
        int t;
        int a;
        int m;
        int arg;
        int nt;
        int lines;
        string text;

        afu_c0_tx = '0;
        afu_c1_tx = '0;
        native_c0_tx_almost_full = 1'b0;
        native_c1_tx_almost_full = 1'b0;
        hold_writes = 1'b0;
        c0_next_valid = 1'b0;
        cycles = 0;
        cycle_limit = 1000;
        reset = 1'b1;
        void'($urandom(52614));

        fd = $fopen("bench/ccis_bridge_stimulus.txt", "r");
        if (fd == 0)
        begin
            stop_with_failure("cannot open the stimulus file");
        end
        lines = 0;
        while ($fgets(text, fd) > 0)
        begin
            lines++;
        end
        cycle_limit = 200 * (lines - 2) + 1000;
        $fclose(fd);
        fd = $fopen("bench/ccis_bridge_stimulus.txt", "r");
        void'($fgets(text, fd));
        void'($fgets(text, fd));

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        // Both almost-full flags start low with the native inputs low
        check_flag("afu_c0_tx_almost_full", afu_c0_tx_almost_full, 1'b0);
        check_flag("afu_c1_tx_almost_full", afu_c1_tx_almost_full, 1'b0);

        forever
        begin
            n = $fscanf(fd, "%h %h %h %h %h %h\n", cmd, t, a, m, arg, nt);
            if (n != 6)
            begin
                break;
            end
            case (cmd)
                0: repeat (arg) next_cycle();
                1: issue_read(t, addr_t'(a), mdata_t'(m), arg, nt);
                2, 3: issue_write(t, addr_t'(a), mdata_t'(m), nt);
                4: hold_writes = (arg != 0);
                5: native_c0_tx_almost_full = (arg != 0);
                6: check_flag("afu_c1_tx_almost_full", afu_c1_tx_almost_full, arg != 0);
                7: drain();
                default: stop_with_failure("unknown command in the stimulus file");
            endcase
        end
        $fclose(fd);
        drain();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/ccis_bridge_consts.svh ====
// Bridge constants for field widths, queue depths and flow control margins
`ifndef CCIS_BRIDGE_CONSTS_SVH
`define CCIS_BRIDGE_CONSTS_SVH

// Line and header field widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 64
`define MDATA_WIDTH 16

// Width of cl_len and cl_num, up to 4 lines per request
`define CL_NUM_WIDTH 2

// Read tag heap entries and outstanding write limit
`define MAX_READ_REQS 16
`define MAX_WRITE_REQS 16

// Items a sender may still push after it sees almost-full
`define ALMOST_FULL_THRESHOLD 4

`define FENCE_FIFO_DEPTH 8

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module ccis_bridge_tb -o ccis_bridge_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/ccis_bridge_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if echo "$output" | grep -q "Everything OK"; then
    exit 0
fi
exit 1

// ==== source/ccis_bridge.sv ====
// Bridge top that maps the AFU port onto the single-line native cache port
`timescale 1ns/10ps
`default_nettype none

module ccis_bridge
    import ccis_bridge_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,

    // AFU side
    input  wire c0_req_t     afu_c0_tx,
    input  wire c1_req_t     afu_c1_tx,
    output logic             afu_c0_tx_almost_full,
    output logic             afu_c1_tx_almost_full,
    output c0_rsp_t          afu_c0_rx,
    output c1_rsp_t          afu_c1_rx,

    // Native side
    output native_req_t      native_c0_tx,
    output native_req_t      native_c1_tx,
    input  wire native_rsp_t native_c0_rx,
    input  wire native_rsp_t native_c1_rx,
    input  wire logic        native_c0_tx_almost_full,
    input  wire logic        native_c1_tx_almost_full
);

    c0_req_t split_req;
    c0_rsp_t native_rd_rsp;
    c1_rsp_t native_c1_rsp;
    logic native_wr_rsp_valid;

    // --------------------
    // Reads

    multi_line_read_splitter splitter
    (
        .clk(clk),
        .reset(reset),
        .afu_req(afu_c0_tx),
        .native_almost_full(native_c0_tx_almost_full),
        .native_rsp(native_rd_rsp),
        .afu_almost_full(afu_c0_tx_almost_full),
        .native_req(split_req),
        .afu_rsp(afu_c0_rx)
    );

    assign native_c0_tx = afu_to_native_c0_req(split_req);

    // Channel 0 carries both kinds, split by response type
    assign native_rd_rsp = native_to_afu_c0_rsp(native_c0_rx);
    assign native_wr_rsp_valid = native_c0_rx.valid && (native_c0_rx.resp_type == NRSP_WRLINE);

    // --------------------
    // Writes and fences

    assign native_c1_tx = afu_to_native_c1_req(afu_c1_tx);
    assign native_c1_rsp = native_to_afu_c1_rsp(native_c1_rx);

    write_response_merger merger
    (
        .clk(clk),
        .reset(reset),
        .write_req(afu_c1_tx),
        .native_wr_rsp_valid(native_wr_rsp_valid),
        .native_wr_rsp_mdata(native_c0_rx.mdata),
        .native_c1_rsp(native_c1_rsp),
        .native_almost_full(native_c1_tx_almost_full),
        .afu_rsp(afu_c1_rx),
        .afu_almost_full(afu_c1_tx_almost_full)
    );

endmodule

`default_nettype wire

// ==== source/ccis_bridge_pkg.sv ====
// Request and response types of the bridge ports and the header translation functions
`default_nettype none

`include "ccis_bridge_consts.svh"

package ccis_bridge_pkg;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [`MDATA_WIDTH-1:0] mdata_t;
    typedef logic [`CL_NUM_WIDTH-1:0] cl_num_t;
    typedef logic [$clog2(`MAX_READ_REQS)-1:0] heap_idx_t;

    // --------------------
    // Request and response kinds

    typedef enum logic [2:0] {
        REQ_RDLINE_I,
        REQ_RDLINE_S,
        REQ_WRLINE_I,
        REQ_WRLINE_M,
        REQ_WRFENCE
    } req_e;

    typedef enum logic [1:0] {
        RSP_RDLINE,
        RSP_WRLINE,
        RSP_WRFENCE
    } rsp_e;

    // Native encodings, zero is not a valid request
    typedef enum logic [3:0] {
        NREQ_NONE     = 4'h0,
        NREQ_WRLINE_I = 4'h1,
        NREQ_WRLINE_M = 4'h2,
        NREQ_RDLINE_S = 4'h4,
        NREQ_WRFENCE  = 4'h5,
        NREQ_RDLINE_I = 4'h6
    } native_req_e;

    typedef enum logic [3:0] {
        NRSP_WRLINE = 4'h1,
        NRSP_RDLINE = 4'h4
    } native_rsp_e;

    // --------------------
    // Port structs

    typedef struct packed {
        logic    valid;
        req_e    req_type;
        addr_t   address;
        mdata_t  mdata;
        cl_num_t cl_len;
    } c0_req_t;

    typedef struct packed {
        logic   valid;
        req_e   req_type;
        addr_t  address;
        mdata_t mdata;
        data_t  data;
    } c1_req_t;

    typedef struct packed {
        logic    valid;
        rsp_e    resp_type;
        mdata_t  mdata;
        cl_num_t cl_num;
        data_t   data;
    } c0_rsp_t;

    typedef struct packed {
        logic   valid;
        rsp_e   resp_type;
        mdata_t mdata;
    } c1_rsp_t;

    typedef struct packed {
        logic        valid;
        native_req_e req_type;
        addr_t       address;
        mdata_t      mdata;
        data_t       data;
    } native_req_t;

    typedef struct packed {
        logic        valid;
        native_rsp_e resp_type;
        mdata_t      mdata;
        data_t       data;
    } native_rsp_t;

    // State saved per native read, restored into the response
    typedef struct packed {
        heap_idx_t orig_mdata;
        cl_num_t   cl_num;
    } heap_entry_t;

    // --------------------
    // Header translation

    function automatic native_req_t afu_to_native_c0_req(c0_req_t r);
        native_req_t n;

        n = '0;
        n.valid = r.valid;
        n.address = r.address;
        n.mdata = r.mdata;
        case (r.req_type)
            REQ_RDLINE_I: n.req_type = NREQ_RDLINE_I;
            REQ_RDLINE_S: n.req_type = NREQ_RDLINE_S;
            default:      n.req_type = NREQ_NONE;
        endcase
        return n;
    endfunction

    // Fences travel as native writes carrying the fence code
    function automatic native_req_t afu_to_native_c1_req(c1_req_t r);
        native_req_t n;

        n = '0;
        n.valid = r.valid;
        n.address = r.address;
        n.mdata = r.mdata;
        n.data = r.data;
        case (r.req_type)
            REQ_WRLINE_I: n.req_type = NREQ_WRLINE_I;
            REQ_WRLINE_M: n.req_type = NREQ_WRLINE_M;
            REQ_WRFENCE:  n.req_type = NREQ_WRFENCE;
            default:      n.req_type = NREQ_NONE;
        endcase
        return n;
    endfunction

    // Only read lines are valid here, write responses take another path
    function automatic c0_rsp_t native_to_afu_c0_rsp(native_rsp_t n);
        c0_rsp_t r;

        r = '0;
        r.valid = n.valid && (n.resp_type == NRSP_RDLINE);
        r.resp_type = RSP_RDLINE;
        r.mdata = n.mdata;
        r.data = n.data;
        return r;
    endfunction

    function automatic c1_rsp_t native_to_afu_c1_rsp(native_rsp_t n);
        c1_rsp_t r;

        r = '0;
        r.valid = n.valid && (n.resp_type == NRSP_WRLINE);
        r.resp_type = RSP_WRLINE;
        r.mdata = n.mdata;
        return r;
    endfunction

endpackage

`default_nettype wire

// ==== source/lutram_fifo.sv ====
// First-word-fall-through FIFO on a circular buffer with an almost-full flag
`timescale 1ns/10ps
`default_nettype none

module lutram_fifo
#(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 8,
    parameter int THRESHOLD = 2
)
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire payload_t enq_data,
    input  wire logic     enq_en,
    input  wire logic     deq_en,
    output payload_t      first,
    output logic          not_empty,
    output logic          almost_full
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    typedef logic [PTR_WIDTH-1:0] ptr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    payload_t mem [DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    count_t count;
    logic do_deq;

    // Depth need not be a power of two
    function automatic ptr_t next_ptr(ptr_t p);
        if (p == ptr_t'(DEPTH - 1))
        begin
            return '0;
        end
        return p + ptr_t'(1);
    endfunction

    assign do_deq = deq_en && not_empty;

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_deq)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + count_t'(enq_en) - count_t'(do_deq);
        end
    end

    assign first = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Free entries at or below the margin
    assign almost_full = (count_t'(DEPTH) - count) <= count_t'(THRESHOLD);

endmodule

`default_nettype wire

// ==== source/multi_line_read_splitter.sv ====
// Read splitter that turns multi-line reads into single-line reads and rebuilds responses
`timescale 1ns/10ps
`default_nettype none

`include "ccis_bridge_consts.svh"

module multi_line_read_splitter
    import ccis_bridge_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire c0_req_t afu_req,
    input  wire logic    native_almost_full,
    input  wire c0_rsp_t native_rsp,
    output logic         afu_almost_full,
    output c0_req_t      native_req,
    output c0_rsp_t      afu_rsp
);

    localparam int REQ_FIFO_DEPTH = `ALMOST_FULL_THRESHOLD + 2;
    localparam int IDX_WIDTH = $bits(heap_idx_t);
    localparam int BEAT_WIDTH = $bits(cl_num_t);

    c0_req_t fifo_first;
    logic fifo_not_empty;
    logic fifo_deq;
    logic issue;
    cl_num_t beat_num;
    logic heap_not_full;
    heap_idx_t heap_alloc_idx;
    heap_entry_t heap_alloc_data;
    heap_entry_t heap_read_data;
    c0_rsp_t rsp_q;
    logic rsp_valid_q;
    heap_idx_t rsp_idx;

    lutram_fifo
    #(
        .payload_t(c0_req_t),
        .DEPTH(REQ_FIFO_DEPTH),
        .THRESHOLD(`ALMOST_FULL_THRESHOLD)
    )
    req_fifo
    (
        .clk(clk),
        .reset(reset),
        .enq_data(afu_req),
        .enq_en(afu_req.valid),
        .deq_en(fifo_deq),
        .first(fifo_first),
        .not_empty(fifo_not_empty),
        .almost_full(afu_almost_full)
    );

    // --------------------
    // Request beats

    assign issue = fifo_not_empty && heap_not_full && !native_almost_full;

    always_comb
    begin
        native_req = fifo_first;
        native_req.valid = issue;
        native_req.cl_len = '0;
        native_req.address[BEAT_WIDTH-1:0] = fifo_first.address[BEAT_WIDTH-1:0] | beat_num;
        native_req.mdata[IDX_WIDTH-1:0] = heap_alloc_idx;

        // Last beat releases the buffered request
        fifo_deq = issue && (beat_num == fifo_first.cl_len);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beat_num <= '0;
        end
        else if (fifo_deq)
        begin
            beat_num <= '0;
        end
        else if (issue)
        begin
            beat_num <= beat_num + cl_num_t'(1);
        end
    end

    assign heap_alloc_data.orig_mdata = fifo_first.mdata[IDX_WIDTH-1:0];
    assign heap_alloc_data.cl_num = beat_num;

    read_tag_heap tag_heap
    (
        .clk(clk),
        .reset(reset),
        .alloc_en(issue),
        .alloc_data(heap_alloc_data),
        .read_idx(rsp_idx),
        .free_en(rsp_valid_q),
        .free_idx(rsp_idx),
        .not_full(heap_not_full),
        .alloc_idx(heap_alloc_idx),
        .read_data(heap_read_data)
    );

    // --------------------
    // Responses, one register stage to look up the heap

    always_ff @(posedge clk)
    begin
        rsp_q <= native_rsp;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= native_rsp.valid;
        end
    end

    assign rsp_idx = rsp_q.mdata[IDX_WIDTH-1:0];

    always_comb
    begin
        afu_rsp = rsp_q;
        afu_rsp.valid = rsp_valid_q;
        afu_rsp.mdata[IDX_WIDTH-1:0] = heap_read_data.orig_mdata;
        afu_rsp.cl_num = heap_read_data.cl_num;
    end

endmodule

`default_nettype wire

// ==== source/read_tag_heap.sv ====
// Tag heap that hands out native read tags and keeps the original request state per tag
`timescale 1ns/10ps
`default_nettype none

`include "ccis_bridge_consts.svh"

module read_tag_heap
    import ccis_bridge_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        alloc_en,
    input  wire heap_entry_t alloc_data,
    input  wire heap_idx_t   read_idx,
    input  wire logic        free_en,
    input  wire heap_idx_t   free_idx,
    output logic             not_full,
    output heap_idx_t        alloc_idx,
    output heap_entry_t      read_data
);

    localparam int ENTRIES = `MAX_READ_REQS;
    localparam int MIN_FREE = `ALMOST_FULL_THRESHOLD + 1;
    localparam int COUNT_WIDTH = $clog2(ENTRIES + 1);

    typedef logic [COUNT_WIDTH-1:0] count_t;

    heap_entry_t storage [ENTRIES];
    logic [ENTRIES-1:0] in_use;
    count_t free_count;

    // Lowest free index wins
    always_comb
    begin
        alloc_idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--)
        begin
            if (!in_use[i])
            begin
                alloc_idx = heap_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            in_use <= '0;
            free_count <= count_t'(ENTRIES);
        end
        else
        begin
            if (alloc_en)
            begin
                in_use[alloc_idx] <= 1'b1;
            end
            if (free_en)
            begin
                in_use[free_idx] <= 1'b0;
            end
            free_count <= free_count - count_t'(alloc_en) + count_t'(free_en);
        end
    end

    always_ff @(posedge clk)
    begin
        if (alloc_en)
        begin
            storage[alloc_idx] <= alloc_data;
        end
    end

    assign read_data = storage[read_idx];

    // Keep room for requests already in flight toward the heap
    assign not_full = (free_count >= count_t'(MIN_FREE));

endmodule

`default_nettype wire

// ==== source/write_response_merger.sv ====
// Write response merger that moves channel 0 write responses and fence responses onto channel 1
`timescale 1ns/10ps
`default_nettype none

`include "ccis_bridge_consts.svh"

module write_response_merger
    import ccis_bridge_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire c1_req_t write_req,
    input  wire logic    native_wr_rsp_valid,
    input  wire mdata_t  native_wr_rsp_mdata,
    input  wire c1_rsp_t native_c1_rsp,
    input  wire logic    native_almost_full,
    output c1_rsp_t      afu_rsp,
    output logic         afu_almost_full
);

    localparam int COUNT_WIDTH = $clog2(`MAX_WRITE_REQS + 1);
    localparam int WRITE_LIMIT = `MAX_WRITE_REQS - `ALMOST_FULL_THRESHOLD;

    typedef logic [COUNT_WIDTH-1:0] count_t;

    logic is_write;
    logic is_fence;
    logic rsp_delivered;
    count_t active_writes;

    mdata_t wr_rsp_mdata;
    logic wr_rsp_not_empty;
    logic wr_rsp_deq;

    mdata_t fence_mdata;
    logic fence_not_empty;
    logic fence_deq;
    logic fence_almost_full;

    assign is_write = write_req.valid &&
                      ((write_req.req_type == REQ_WRLINE_I) ||
                       (write_req.req_type == REQ_WRLINE_M));
    assign is_fence = write_req.valid && (write_req.req_type == REQ_WRFENCE);

    assign rsp_delivered = afu_rsp.valid && (afu_rsp.resp_type == RSP_WRLINE);

    // --------------------
    // Outstanding write count

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active_writes <= '0;
        end
        else if (is_write && !rsp_delivered)
        begin
            active_writes <= active_writes + count_t'(1);
        end
        else if (!is_write && rsp_delivered)
        begin
            active_writes <= active_writes - count_t'(1);
        end
    end

    // The count also bounds the channel 0 response queue
    assign afu_almost_full = native_almost_full ||
                             (active_writes >= count_t'(WRITE_LIMIT)) ||
                             fence_almost_full;

    // --------------------
    // Response queues

    lutram_fifo
    #(
        .payload_t(mdata_t),
        .DEPTH(`MAX_WRITE_REQS),
        .THRESHOLD(`ALMOST_FULL_THRESHOLD)
    )
    wr_rsp_fifo
    (
        .clk(clk),
        .reset(reset),
        .enq_data(native_wr_rsp_mdata),
        .enq_en(native_wr_rsp_valid),
        .deq_en(wr_rsp_deq),
        .first(wr_rsp_mdata),
        .not_empty(wr_rsp_not_empty),
        .almost_full()
    );

    lutram_fifo
    #(
        .payload_t(mdata_t),
        .DEPTH(`FENCE_FIFO_DEPTH),
        .THRESHOLD(`ALMOST_FULL_THRESHOLD + 1)
    )
    fence_fifo
    (
        .clk(clk),
        .reset(reset),
        .enq_data(write_req.mdata),
        .enq_en(is_fence),
        .deq_en(fence_deq),
        .first(fence_mdata),
        .not_empty(fence_not_empty),
        .almost_full(fence_almost_full)
    );

    // Native channel 1 first, then queued writes, then fences
    always_comb
    begin
        afu_rsp = native_c1_rsp;
        wr_rsp_deq = 1'b0;
        fence_deq = 1'b0;

        if (!native_c1_rsp.valid && wr_rsp_not_empty)
        begin
            afu_rsp.valid = 1'b1;
            afu_rsp.resp_type = RSP_WRLINE;
            afu_rsp.mdata = wr_rsp_mdata;
            wr_rsp_deq = 1'b1;
        end
        else if (!native_c1_rsp.valid && fence_not_empty)
        begin
            afu_rsp.valid = 1'b1;
            afu_rsp.resp_type = RSP_WRFENCE;
            afu_rsp.mdata = fence_mdata;
            fence_deq = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
source/ccis_bridge_pkg.sv
source/lutram_fifo.sv
source/read_tag_heap.sv
source/multi_line_read_splitter.sv
source/write_response_merger.sv
source/ccis_bridge.sv
bench/ccis_bridge_tb.sv
